// ==== rtl/tcls_pkg.sv ====
// Lockstep unit definitions
package tcls_pkg;

  // Core count and bus sizes
  localparam int unsigned NUM_CORES = 3;
  localparam int unsigned IDX_W     = $clog2(NUM_CORES);
  localparam int unsigned ADDR_W    = 8;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned MEM_DEPTH = 256;

  // Interrupt id used to request resynchronization
  localparam int unsigned IRQ_ID_W      = 5;
  localparam int unsigned RESYNC_IRQ_ID = 31;

  localparam int unsigned CNT_W = 16;

  // Vote widths: {req, busy, irq_ack} and {we, addr, wdata}
  localparam int unsigned CTRL_VOTE_W = 3;
  localparam int unsigned DATA_VOTE_W = 1 + ADDR_W + DATA_W;

  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } redundancy_mode_e;

  // Register map of the configuration port
  typedef enum logic [2:0] {
    REG_MODE       = 3'd0,
    REG_SP_STORE   = 3'd1,
    REG_MISMATCH_0 = 3'd2,
    REG_MISMATCH_1 = 3'd3,
    REG_MISMATCH_2 = 3'd4
  } reg_addr_e;

endpackage

// ==== rtl/tmr_voter.sv ====
// Bitwise majority voter
`timescale 1ns/1ps

module tmr_voter #(
  parameter int unsigned VOTE_W = 8
) (
  input  logic [VOTE_W-1:0] a_i,
  input  logic [VOTE_W-1:0] b_i,
  input  logic [VOTE_W-1:0] c_i,
  output logic [VOTE_W-1:0] majority_o,
  output logic              error_o,
  output logic [2:0]        error_cba_o
);

  logic [VOTE_W-1:0] maj;

  // Two of three inputs decide each bit
  assign maj = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign majority_o = maj;

  // Bit 0 blames a, bit 2 blames c
  assign error_cba_o[0] = (a_i != maj);
  assign error_cba_o[1] = (b_i != maj);
  assign error_cba_o[2] = (c_i != maj);

  assign error_o = |error_cba_o;

endmodule

// ==== rtl/tcls_regs.sv ====
// Lockstep configuration registers
`timescale 1ns/1ps

module tcls_regs import tcls_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reg_req_i,
  input  logic                 reg_we_i,
  input  logic [2:0]           reg_addr_i,
  input  logic [DATA_W-1:0]    reg_wdata_i,
  output logic [DATA_W-1:0]    reg_rdata_o,
  output logic                 tmr_en_o,
  output logic                 restore_mode_o,
  output logic [DATA_W-1:0]    sp_store_o,
  input  logic [NUM_CORES-1:0] mismatch_inc_i
);

  logic [1:0]                       mode_q;
  logic [DATA_W-1:0]                sp_store_q;
  logic [NUM_CORES-1:0][CNT_W-1:0]  cnt_q;
  logic [NUM_CORES-1:0]             cnt_clr;
  logic                             wr_en;

  assign wr_en = reg_req_i & reg_we_i;

  // Decode counter clears
  always_comb begin
    cnt_clr = '0;
    if (wr_en) begin
      case (reg_addr_e'(reg_addr_i))
        REG_MISMATCH_0: cnt_clr[0] = 1'b1;
        REG_MISMATCH_1: cnt_clr[1] = 1'b1;
        REG_MISMATCH_2: cnt_clr[2] = 1'b1;
        default:        cnt_clr    = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= '0;
      sp_store_q <= '0;
    end else if (wr_en) begin
      if (reg_addr_e'(reg_addr_i) == REG_MODE) begin
        mode_q <= reg_wdata_i[1:0];
      end
      if (reg_addr_e'(reg_addr_i) == REG_SP_STORE) begin
        sp_store_q <= reg_wdata_i;
      end
    end
  end

  // Saturating mismatch counters, clear has priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CORES; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (mismatch_inc_i[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_req_i) begin
      case (reg_addr_e'(reg_addr_i))
        REG_MODE:       reg_rdata_o = DATA_W'(mode_q);
        REG_SP_STORE:   reg_rdata_o = sp_store_q;
        REG_MISMATCH_0: reg_rdata_o = DATA_W'(cnt_q[0]);
        REG_MISMATCH_1: reg_rdata_o = DATA_W'(cnt_q[1]);
        REG_MISMATCH_2: reg_rdata_o = DATA_W'(cnt_q[2]);
        default:        reg_rdata_o = '0;
      endcase
    end
  end

  assign tmr_en_o       = mode_q[0];
  assign restore_mode_o = mode_q[1];
  assign sp_store_o     = sp_store_q;

endmodule

// ==== rtl/tcls_unit.sv ====
// Triple-core lockstep unit
`timescale 1ns/1ps

module tcls_unit import tcls_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                fetch_en_i,
  // Core side
  input  logic [NUM_CORES-1:0]                core_req_i,
  input  logic [NUM_CORES-1:0]                core_we_i,
  input  logic [NUM_CORES-1:0][ADDR_W-1:0]    core_addr_i,
  input  logic [NUM_CORES-1:0][DATA_W-1:0]    core_wdata_i,
  input  logic [NUM_CORES-1:0]                core_busy_i,
  input  logic [NUM_CORES-1:0]                core_irq_ack_i,
  output logic [NUM_CORES-1:0]                core_gnt_o,
  output logic [NUM_CORES-1:0]                core_rvalid_o,
  output logic [NUM_CORES-1:0][DATA_W-1:0]    core_rdata_o,
  output logic [NUM_CORES-1:0]                core_irq_req_o,
  output logic [NUM_CORES-1:0][IRQ_ID_W-1:0]  core_irq_id_o,
  // System interrupt side
  input  logic [NUM_CORES-1:0]                irq_req_i,
  input  logic [NUM_CORES-1:0][IRQ_ID_W-1:0]  irq_id_i,
  output logic [NUM_CORES-1:0]                irq_ack_o,
  output logic                                busy_o,
  // Arbiter side
  output logic [NUM_CORES-1:0]                bus_req_o,
  output logic [NUM_CORES-1:0]                bus_we_o,
  output logic [NUM_CORES-1:0][ADDR_W-1:0]    bus_addr_o,
  output logic [NUM_CORES-1:0][DATA_W-1:0]    bus_wdata_o,
  input  logic [NUM_CORES-1:0]                bus_gnt_i,
  input  logic [NUM_CORES-1:0]                bus_rvalid_i,
  input  logic [NUM_CORES-1:0][DATA_W-1:0]    bus_rdata_i,
  // Configuration
  input  logic                                tmr_en_i,
  input  logic                                restore_mode_i,
  input  logic [DATA_W-1:0]                   sp_store_i,
  output logic [NUM_CORES-1:0]                mismatch_inc_o
);

  redundancy_mode_e red_mode_d, red_mode_q;

  logic [NUM_CORES-1:0][CTRL_VOTE_W-1:0] ctrl_in;
  logic [NUM_CORES-1:0][DATA_VOTE_W-1:0] data_in;
  logic [CTRL_VOTE_W-1:0]                ctrl_vote;
  logic [DATA_VOTE_W-1:0]                data_vote;
  logic                                  ctrl_err, data_err, mismatch;
  logic [2:0]                            ctrl_cba, data_cba, err_detect;
  logic                                  v_req, v_busy, v_ack, v_we;
  logic [ADDR_W-1:0]                     v_addr;
  logic [DATA_W-1:0]                     v_wdata;
  logic                                  lockstep;

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_vote_in
    assign ctrl_in[i] = {core_req_i[i], core_busy_i[i], core_irq_ack_i[i]};
    assign data_in[i] = {core_we_i[i], core_addr_i[i], core_wdata_i[i]};
  end

  tmr_voter #(.VOTE_W(CTRL_VOTE_W)) u_ctrl_voter (
    .a_i        (ctrl_in[0]),
    .b_i        (ctrl_in[1]),
    .c_i        (ctrl_in[2]),
    .majority_o (ctrl_vote),
    .error_o    (ctrl_err),
    .error_cba_o(ctrl_cba)
  );

  tmr_voter #(.VOTE_W(DATA_VOTE_W)) u_data_voter (
    .a_i        (data_in[0]),
    .b_i        (data_in[1]),
    .c_i        (data_in[2]),
    .majority_o (data_vote),
    .error_o    (data_err),
    .error_cba_o(data_cba)
  );

  assign {v_req, v_busy, v_ack}   = ctrl_vote;
  assign {v_we, v_addr, v_wdata}  = data_vote;

  // Data fields only matter while a request is out
  assign mismatch   = ctrl_err | (v_req & data_err);
  assign err_detect = ctrl_cba | (v_req ? data_cba : 3'b000);

  always_comb begin
    mismatch_inc_o = '0;
    if (red_mode_q == TMR_RUN) begin
      if (err_detect == 3'b001 || err_detect == 3'b010 || err_detect == 3'b100) begin
        mismatch_inc_o = err_detect;
      end
    end
  end

  always_comb begin
    red_mode_d = red_mode_q;
    case (red_mode_q)
      TMR_RUN: if (mismatch && !restore_mode_i) red_mode_d = TMR_UNLOAD;
      TMR_UNLOAD: if (sp_store_i != '0) red_mode_d = TMR_RELOAD;
      TMR_RELOAD: if (sp_store_i == '0) red_mode_d = TMR_RUN;
      default: red_mode_d = red_mode_q;
    endcase
    // Mode follows the register while core 0 is idle and not fetching
    if (!fetch_en_i && !core_busy_i[0]) begin
      red_mode_d = tmr_en_i ? TMR_RUN : NON_TMR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      red_mode_q <= NON_TMR;
    end else begin
      red_mode_q <= red_mode_d;
    end
  end

  assign lockstep = (red_mode_q != NON_TMR);
  assign busy_o   = lockstep ? v_busy : core_busy_i[0];

  // Interrupt routing, resync request overrides in unload and reload
  always_comb begin
    core_irq_req_o = irq_req_i;
    core_irq_id_o  = irq_id_i;
    irq_ack_o      = core_irq_ack_i;
    if (lockstep) begin
      irq_ack_o = '0;
      for (int i = 0; i < NUM_CORES; i++) begin
        core_irq_req_o[i] = irq_req_i[0];
        core_irq_id_o[i]  = irq_id_i[0];
      end
      if (red_mode_q == TMR_UNLOAD || red_mode_q == TMR_RELOAD) begin
        core_irq_req_o = '1;
        for (int i = 0; i < NUM_CORES; i++) begin
          core_irq_id_o[i] = IRQ_ID_W'(RESYNC_IRQ_ID);
        end
      end else begin
        irq_ack_o[0] = v_ack;
      end
    end
  end

  // Data bus routing
  always_comb begin
    bus_req_o     = core_req_i;
    bus_we_o      = core_we_i;
    bus_addr_o    = core_addr_i;
    bus_wdata_o   = core_wdata_i;
    core_gnt_o    = bus_gnt_i;
    core_rvalid_o = bus_rvalid_i;
    core_rdata_o  = bus_rdata_i;
    if (lockstep) begin
      bus_req_o      = '0;
      bus_we_o       = '0;
      bus_addr_o     = '0;
      bus_wdata_o    = '0;
      bus_req_o[0]   = v_req;
      bus_we_o[0]    = v_we;
      bus_addr_o[0]  = v_addr;
      bus_wdata_o[0] = v_wdata;
      for (int i = 0; i < NUM_CORES; i++) begin
        core_gnt_o[i]    = bus_gnt_i[0];
        core_rvalid_o[i] = bus_rvalid_i[0];
        core_rdata_o[i]  = bus_rdata_i[0];
      end
    end
  end

endmodule

// ==== rtl/data_arbiter.sv ====
// Round-robin data port arbiter
`timescale 1ns/1ps

module data_arbiter import tcls_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [NUM_CORES-1:0]             req_i,
  input  logic [NUM_CORES-1:0]             we_i,
  input  logic [NUM_CORES-1:0][ADDR_W-1:0] addr_i,
  input  logic [NUM_CORES-1:0][DATA_W-1:0] wdata_i,
  output logic [NUM_CORES-1:0]             gnt_o,
  output logic [NUM_CORES-1:0]             rvalid_o,
  output logic [NUM_CORES-1:0][DATA_W-1:0] rdata_o,
  output logic                             mem_req_o,
  output logic                             mem_we_o,
  output logic [ADDR_W-1:0]                mem_addr_o,
  output logic [DATA_W-1:0]                mem_wdata_o,
  input  logic [DATA_W-1:0]                mem_rdata_i
);

  logic [IDX_W-1:0] last_q, win_idx, port_q;
  logic             any_gnt, valid_q;

  // Search starts one past the last winner
  always_comb begin : proc_grant
    int idx;
    gnt_o   = '0;
    win_idx = last_q;
    any_gnt = 1'b0;
    for (int k = 1; k <= NUM_CORES; k++) begin
      idx = (int'(last_q) + k) % NUM_CORES;
      if (!any_gnt && req_i[idx]) begin
        any_gnt = 1'b1;
        win_idx = IDX_W'(idx);
      end
    end
    if (any_gnt) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign mem_req_o   = any_gnt;
  assign mem_we_o    = we_i[win_idx];
  assign mem_addr_o  = addr_i[win_idx];
  assign mem_wdata_o = wdata_i[win_idx];

  // Reset pointer makes core 0 win first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q  <= IDX_W'(NUM_CORES - 1);
      port_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= any_gnt;
      if (any_gnt) begin
        last_q <= win_idx;
        port_q <= win_idx;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CORES; i++) begin
      rvalid_o[i] = valid_q && (port_q == IDX_W'(i));
      rdata_o[i]  = rvalid_o[i] ? mem_rdata_i : '0;
    end
  end

endmodule

// ==== rtl/shared_mem.sv ====
// Shared single-port data memory
`timescale 1ns/1ps

module shared_mem import tcls_pkg::*; (
  input  logic              clk_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem_q [MEM_DEPTH];
  logic [DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        // Read word shows up in the following cycle
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== rtl/tcls_top.sv ====
// Lockstep system top level
`timescale 1ns/1ps

module tcls_top import tcls_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               fetch_en_i,
  input  logic [NUM_CORES-1:0]               core_req_i,
  input  logic [NUM_CORES-1:0]               core_we_i,
  input  logic [NUM_CORES-1:0][ADDR_W-1:0]   core_addr_i,
  input  logic [NUM_CORES-1:0][DATA_W-1:0]   core_wdata_i,
  output logic [NUM_CORES-1:0]               core_gnt_o,
  output logic [NUM_CORES-1:0]               core_rvalid_o,
  output logic [NUM_CORES-1:0][DATA_W-1:0]   core_rdata_o,
  input  logic [NUM_CORES-1:0]               core_busy_i,
  input  logic [NUM_CORES-1:0]               core_irq_ack_i,
  output logic [NUM_CORES-1:0]               core_irq_req_o,
  output logic [NUM_CORES-1:0][IRQ_ID_W-1:0] core_irq_id_o,
  input  logic [NUM_CORES-1:0]               irq_req_i,
  input  logic [NUM_CORES-1:0][IRQ_ID_W-1:0] irq_id_i,
  output logic [NUM_CORES-1:0]               irq_ack_o,
  output logic                               busy_o,
  input  logic                               reg_req_i,
  input  logic                               reg_we_i,
  input  logic [2:0]                         reg_addr_i,
  input  logic [DATA_W-1:0]                  reg_wdata_i,
  output logic [DATA_W-1:0]                  reg_rdata_o
);

  logic [NUM_CORES-1:0]             bus_req, bus_we, bus_gnt, bus_rvalid;
  logic [NUM_CORES-1:0][ADDR_W-1:0] bus_addr;
  logic [NUM_CORES-1:0][DATA_W-1:0] bus_wdata, bus_rdata;
  logic                             mem_req, mem_we;
  logic [ADDR_W-1:0]                mem_addr;
  logic [DATA_W-1:0]                mem_wdata, mem_rdata, sp_store;
  logic                             tmr_en, restore_mode;
  logic [NUM_CORES-1:0]             mismatch_inc;

  tcls_unit u_unit (
    .clk_i, .rst_ni, .fetch_en_i,
    .core_req_i, .core_we_i, .core_addr_i, .core_wdata_i,
    .core_busy_i, .core_irq_ack_i,
    .core_gnt_o, .core_rvalid_o, .core_rdata_o,
    .core_irq_req_o, .core_irq_id_o,
    .irq_req_i, .irq_id_i, .irq_ack_o, .busy_o,
    .bus_req_o     (bus_req),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_wdata_o   (bus_wdata),
    .bus_gnt_i     (bus_gnt),
    .bus_rvalid_i  (bus_rvalid),
    .bus_rdata_i   (bus_rdata),
    .tmr_en_i      (tmr_en),
    .restore_mode_i(restore_mode),
    .sp_store_i    (sp_store),
    .mismatch_inc_o(mismatch_inc)
  );

  tcls_regs u_regs (
    .clk_i, .rst_ni,
    .reg_req_i, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .tmr_en_o      (tmr_en),
    .restore_mode_o(restore_mode),
    .sp_store_o    (sp_store),
    .mismatch_inc_i(mismatch_inc)
  );

  data_arbiter u_arb (
    .clk_i, .rst_ni,
    .req_i      (bus_req),
    .we_i       (bus_we),
    .addr_i     (bus_addr),
    .wdata_i    (bus_wdata),
    .gnt_o      (bus_gnt),
    .rvalid_o   (bus_rvalid),
    .rdata_o    (bus_rdata),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata)
  );

  shared_mem u_mem (
    .clk_i,
    .req_i  (mem_req),
    .we_i   (mem_we),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

endmodule

// ==== dv/tcls_properties.sv ====
// Lockstep top level assertions
`timescale 1ns/1ps

module tcls_properties import tcls_pkg::*; (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic [NUM_CORES-1:0]               bus_gnt_i,
  input logic [NUM_CORES-1:0]               bus_rvalid_i,
  input logic [NUM_CORES-1:0]               core_gnt_i,
  input logic [NUM_CORES-1:0][DATA_W-1:0]   core_rdata_i,
  input logic [NUM_CORES-1:0][IRQ_ID_W-1:0] core_irq_id_i,
  input redundancy_mode_e                   mode_i
);

  logic lockstep;

  assign lockstep = (mode_i != NON_TMR);

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(bus_gnt_i))
    else $error("more than one arbiter grant in a cycle");

  // Response goes to exactly the ports accepted one cycle before
  a_rvalid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    1'b1 |=> (bus_rvalid_i == $past(bus_gnt_i)))
    else $error("rvalid does not follow the accept by one cycle");

  a_lockstep_equal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lockstep |-> (core_gnt_i == {NUM_CORES{core_gnt_i[0]}})
                 && (core_rdata_i[1] == core_rdata_i[0])
                 && (core_rdata_i[2] == core_rdata_i[0]))
    else $error("cores see different responses in lockstep");

  a_unload_irq_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_i == TMR_UNLOAD) |-> (core_irq_id_i == {NUM_CORES{IRQ_ID_W'(RESYNC_IRQ_ID)}}))
    else $error("wrong interrupt id during unload");

endmodule

bind tcls_top tcls_properties u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .bus_gnt_i    (bus_gnt),
  .bus_rvalid_i (bus_rvalid),
  .core_gnt_i   (core_gnt_o),
  .core_rdata_i (core_rdata_o),
  .core_irq_id_i(core_irq_id_o),
  .mode_i       (u_unit.red_mode_q)
);

// ==== dv/tcls_tb.sv ====
// Lockstep unit testbench
`timescale 1ns/1ps

module tcls_tb import tcls_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int MAX_CYCLES = 2000;
  localparam int SEED       = 78148;

  logic                               clk_i, rst_ni, fetch_en_i;
  logic [NUM_CORES-1:0]               core_req_i, core_we_i, core_busy_i, core_irq_ack_i;
  logic [NUM_CORES-1:0][ADDR_W-1:0]   core_addr_i;
  logic [NUM_CORES-1:0][DATA_W-1:0]   core_wdata_i, core_rdata_o;
  logic [NUM_CORES-1:0]               core_gnt_o, core_rvalid_o, core_irq_req_o;
  logic [NUM_CORES-1:0][IRQ_ID_W-1:0] core_irq_id_o, irq_id_i;
  logic [NUM_CORES-1:0]               irq_req_i, irq_ack_o;
  logic                               busy_o, reg_req_i, reg_we_i;
  logic [2:0]                         reg_addr_i;
  logic [DATA_W-1:0]                  reg_wdata_i, reg_rdata_o;

  // Grant vectors seen per accept cycle, and read data per core
  logic [NUM_CORES-1:0]             gnt_log[$];
  logic [NUM_CORES-1:0][DATA_W-1:0] rdata_seen;
  int                               cycles = 0;

  tcls_top uut (.*);

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [DATA_W-1:0] data);
    reg_req_i   = 1'b1;
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
  endtask

  // Read data is combinational, so it is sampled inside the request cycle
  task automatic check_reg(input reg_addr_e addr, input logic [DATA_W-1:0] exp,
                           input string what);
    logic [DATA_W-1:0] data;
    reg_req_i  = 1'b1;
    reg_we_i   = 1'b0;
    reg_addr_i = addr;
    #1;
    data = reg_rdata_o;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    check_eq(64'(data), 64'(exp), what);
  endtask

  // Hold requests on the masked ports until each is accepted, then collect responses
  task automatic serve_bus(input logic [NUM_CORES-1:0] mask);
    logic [NUM_CORES-1:0] pending;
    logic [NUM_CORES-1:0] prev;
    logic [NUM_CORES-1:0] gnt;
    pending = mask;
    prev    = '0;
    gnt_log.delete();
    while (pending != '0 || prev != '0) begin
      core_req_i = pending;
      #1;
      gnt = core_gnt_o;
      check_eq(64'(gnt & ~pending), 64'(0), "grant without request");
      check_eq(64'(core_rvalid_o), 64'(prev), "rvalid one cycle after accept");
      for (int i = 0; i < NUM_CORES; i++) begin
        if (prev[i]) begin
          rdata_seen[i] = core_rdata_o[i];
        end
      end
      if (gnt != '0) begin
        gnt_log.push_back(gnt);
      end
      prev    = gnt;
      pending = pending & ~gnt;
      @(negedge clk_i);
    end
    core_req_i = '0;
  endtask

  task automatic test_reset();
    for (int a = 0; a < 5; a++) begin
      check_reg(reg_addr_e'(a), '0, "register after reset");
    end
    check_eq(64'({core_gnt_o, core_rvalid_o, core_irq_req_o}), 64'(0), "outputs after reset");
  endtask

  task automatic test_independent();
    logic [NUM_CORES-1:0][DATA_W-1:0] words;
    for (int i = 0; i < NUM_CORES; i++) begin
      words[i]       = $urandom();
      core_addr_i[i] = ADDR_W'(16 + i);
    end
    core_wdata_i = words;
    core_we_i    = '1;
    serve_bus(3'b111);
    check_eq(64'(gnt_log.size()), 64'(3), "number of accept cycles");
    for (int i = 0; i < NUM_CORES; i++) begin
      check_eq(64'(gnt_log[i]), 64'(1 << i), "round-robin grant order");
    end
    core_we_i = '0;
    serve_bus(3'b111);
    for (int i = 0; i < NUM_CORES; i++) begin
      check_eq(64'(rdata_seen[i]), 64'(words[i]), "own word read back");
    end
    irq_req_i      = 3'b101;
    irq_id_i       = {5'd3, 5'd2, 5'd1};
    core_irq_ack_i = 3'b010;
    #1;
    check_eq(64'(core_irq_req_o), 64'(3'b101), "irq request pass-through");
    check_eq(64'(core_irq_id_o), 64'({5'd3, 5'd2, 5'd1}), "irq id pass-through");
    check_eq(64'(irq_ack_o), 64'(3'b010), "irq ack pass-through");
    @(negedge clk_i);
    irq_req_i      = '0;
    irq_id_i       = '0;
    core_irq_ack_i = '0;
    // Busy comes from core 0 alone outside lockstep
    core_busy_i = 3'b110;
    #1;
    check_eq(64'(busy_o), 64'(0), "busy of idle core 0");
    @(negedge clk_i);
    core_busy_i = 3'b001;
    #1;
    check_eq(64'(busy_o), 64'(1), "busy of busy core 0");
    @(negedge clk_i);
    core_busy_i = '0;
  endtask

  task automatic test_lockstep_agree();
    logic [DATA_W-1:0] word;
    word = $urandom();
    // Mode is picked up while fetch is still low
    reg_write(REG_MODE, 32'h1);
    @(negedge clk_i);
    fetch_en_i   = 1'b1;
    core_we_i    = '1;
    core_addr_i  = {NUM_CORES{8'h20}};
    core_wdata_i = {NUM_CORES{word}};
    serve_bus(3'b111);
    check_eq(64'(gnt_log.size()), 64'(1), "memory writes in lockstep");
    check_eq(64'(gnt_log[0]), 64'(3'b111), "shared grant");
    core_we_i = '0;
    serve_bus(3'b111);
    for (int i = 0; i < NUM_CORES; i++) begin
      check_eq(64'(rdata_seen[i]), 64'(word), "lockstep read data");
    end
    check_reg(REG_MISMATCH_0, '0, "counter 0 with agreeing cores");
    check_reg(REG_MISMATCH_1, '0, "counter 1 with agreeing cores");
    check_reg(REG_MISMATCH_2, '0, "counter 2 with agreeing cores");
  endtask

  task automatic test_fault_unload();
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] sp;
    word         = $urandom();
    sp           = $urandom() | 32'h1;
    core_we_i    = '1;
    core_addr_i  = {NUM_CORES{8'h30}};
    core_wdata_i = {word, ~word, word};
    serve_bus(3'b111);
    core_wdata_i = {NUM_CORES{word}};
    check_eq(64'(core_irq_req_o), 64'(3'b111), "resync irq request");
    check_eq(64'(core_irq_id_o), 64'({NUM_CORES{5'd31}}), "resync irq id");
    check_reg(REG_MISMATCH_1, 32'd1, "faulty core counter");
    check_reg(REG_MISMATCH_0, '0, "healthy core 0 counter");
    check_reg(REG_MISMATCH_2, '0, "healthy core 2 counter");
    check_eq(64'(core_irq_req_o), 64'(3'b111), "resync irq held in unload");
    core_irq_ack_i = '1;
    #1;
    check_eq(64'(irq_ack_o), 64'(0), "irq ack in unload");
    @(negedge clk_i);
    core_irq_ack_i = '0;
    reg_write(REG_SP_STORE, sp);
    @(negedge clk_i);
    check_eq(64'(uut.u_unit.red_mode_q), 64'(TMR_RELOAD), "state after sp store write");
    check_eq(64'(core_irq_req_o), 64'(3'b111), "resync irq held in reload");
    check_eq(64'(core_irq_id_o), 64'({NUM_CORES{5'd31}}), "resync irq id in reload");
    reg_write(REG_SP_STORE, '0);
    @(negedge clk_i);
    check_eq(64'(uut.u_unit.red_mode_q), 64'(TMR_RUN), "state after sp store clear");
    irq_req_i = 3'b001;
    irq_id_i  = {5'd9, 5'd8, 5'd7};
    #1;
    check_eq(64'(core_irq_req_o), 64'(3'b111), "irq request broadcast");
    check_eq(64'(core_irq_id_o), 64'({NUM_CORES{5'd7}}), "irq id broadcast");
    @(negedge clk_i);
    irq_req_i = '0;
    irq_id_i  = '0;
    core_we_i = '0;
    serve_bus(3'b111);
    for (int i = 0; i < NUM_CORES; i++) begin
      check_eq(64'(rdata_seen[i]), 64'(word), "majority word in memory");
    end
  endtask

  task automatic test_restore();
    logic [DATA_W-1:0] word;
    word = $urandom();
    reg_write(REG_MODE, 32'h3);
    core_we_i    = '1;
    core_addr_i  = {NUM_CORES{8'h40}};
    core_wdata_i = {~word, word, word};
    serve_bus(3'b111);
    core_wdata_i = {NUM_CORES{word}};
    core_we_i    = '0;
    check_reg(REG_MISMATCH_2, 32'd1, "one mismatching write");
    // Core 2 alone requests and is outvoted for three cycles
    core_req_i = 3'b100;
    repeat (3) begin
      #1;
      check_eq(64'(core_gnt_o), 64'(0), "outvoted request granted");
      check_eq(64'(core_irq_req_o), 64'(0), "resync irq with restore on");
      @(negedge clk_i);
    end
    core_req_i = '0;
    check_reg(REG_MISMATCH_2, 32'd4, "counter per mismatching cycle");
    check_eq(64'(core_irq_req_o), 64'(0), "resync irq after restore faults");
    // Cores 1 and 2 outvote an idle core 0 on busy
    core_busy_i = 3'b110;
    #1;
    check_eq(64'(busy_o), 64'(1), "voted busy in lockstep");
    @(negedge clk_i);
    core_busy_i = '0;
    check_reg(REG_MISMATCH_0, 32'd1, "counter 0 after busy fault");
  endtask

  task automatic test_clear();
    reg_write(REG_MISMATCH_2, $urandom());
    check_reg(REG_MISMATCH_2, '0, "counter 2 after clear");
    reg_write(REG_MISMATCH_1, '0);
    check_reg(REG_MISMATCH_1, '0, "counter 1 after clear");
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni         = 1'b0;
    fetch_en_i     = 1'b0;
    core_req_i     = '0;
    core_we_i      = '0;
    core_addr_i    = '0;
    core_wdata_i   = '0;
    core_busy_i    = '0;
    core_irq_ack_i = '0;
    irq_req_i      = '0;
    irq_id_i       = '0;
    reg_req_i      = 1'b0;
    reg_we_i       = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_reset();
    test_independent();
    test_lockstep_agree();
    test_fault_unload();
    test_restore();
    test_clear();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== tcls.f ====
rtl/tcls_pkg.sv
rtl/tmr_voter.sv
rtl/tcls_regs.sv
rtl/tcls_unit.sv
rtl/data_arbiter.sv
rtl/shared_mem.sv
rtl/tcls_top.sv
dv/tcls_properties.sv
dv/tcls_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tcls_tb -f tcls.f -o tcls_sim

# A fatal check ends the simulation with an error status, keep its output
out=$(./obj_dir/tcls_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi
